//--- verilog/icache_params.svh
// Width and geometry defines for the instruction cache
// Address split is tag, set, word offset, byte offset

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Instruction and bus word width
`define WORD_BITS 32

// Physical byte address width
`define ADDR_BITS 32

// 16 sets
`define SET_BITS 4

// Four words per line
`define OFFSET_BITS 2

// Whatever is left above set, word offset and byte offset
`define TAG_BITS (`ADDR_BITS - `SET_BITS - `OFFSET_BITS - 2)

`endif

//--- verilog/cacheLinePkg.sv
// Address field types and the tag entry type of the cache line

`include "icache_params.svh"

package cacheLinePkg;

  // Upper address bits kept in the tag array
  typedef logic [`TAG_BITS-1:0] tagT;

  // Set index
  typedef logic [`SET_BITS-1:0] setT;

  // Word position within a line
  typedef logic [`OFFSET_BITS-1:0] wordOffT;

  // One tag array entry, valid flag on top
  typedef struct packed {
    logic valid;
    tagT  tag;
  } tagEntryT;

endpackage

//--- verilog/fetchBusPkg.sv
// Word and address types shared by the fetch port and the memory bus

`include "icache_params.svh"

package fetchBusPkg;

  // Instruction or bus data word
  typedef logic [`WORD_BITS-1:0] wordT;

  // Physical byte address
  typedef logic [`ADDR_BITS-1:0] addrT;

endpackage

//--- verilog/cacheArray.sv
// Generic storage array with asynchronous read and clocked write
// Entry type is a parameter so tags and data share this block

module cacheArray #(
  parameter type entryT = logic [31:0],
  parameter int DEPTH = 16,
  localparam int IDX_BITS = $clog2(DEPTH)
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                writeEnable,
  input  logic [IDX_BITS-1:0] writeIndex,
  input  logic [IDX_BITS-1:0] readIndex,
  input  entryT               writeData,
  output entryT               readData
);

  entryT mem [DEPTH];

  // Clearing on reset drops every tag valid flag
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (writeEnable) begin
      mem[writeIndex] <= writeData;
    end
  end

  // Same-cycle lookup for the hit decision
  assign readData = mem[readIndex];

endmodule

//--- verilog/lruTable.sv
// Replacement bit per set for the two-way cache
// High bit means way 1 goes next

`include "icache_params.svh"

module lruTable
  import cacheLinePkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic touch,
  input  setT  touchSet,
  input  setT  readSet,
  input  logic touchedWay1,
  output logic currLru
);

  localparam int NUM_SETS = 1 << `SET_BITS;

  logic [NUM_SETS-1:0] lruBits;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      // Every set starts out pointing at way 1
      lruBits <= '1;
    end else if (touch) begin
      // Most recent way becomes the one kept
      lruBits[touchSet] <= ~touchedWay1;
    end
  end

  assign currLru = lruBits[readSet];

endmodule

//--- verilog/icacheDatapath.sv
// Tag and data arrays of both ways, hit detection and output word select
// Also holds the LRU table for the addressed set

`include "icache_params.svh"

module icacheDatapath
  import cacheLinePkg::*;
  import fetchBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    enable,
  input  addrT    fetchAddr,
  input  wordOffT wordOffsetSel,
  input  logic    way1WriteEnable,
  input  logic    way2WriteEnable,
  input  logic    tagWrite,
  input  logic    waySel,
  input  logic    lruTouch,
  input  wordT    busData,
  output wordT    instr,
  output logic    way1Hit,
  output logic    way2Hit,
  output logic    way1Valid,
  output logic    way2Valid,
  output logic    currLru
);

  localparam int NUM_SETS = 1 << `SET_BITS;
  localparam int NUM_WORDS = 1 << (`SET_BITS + `OFFSET_BITS);

  tagT      addrTag;
  setT      addrSet;
  tagEntryT way1Entry;
  tagEntryT way2Entry;
  tagEntryT newEntry;
  wordT     way1Word;
  wordT     way2Word;
  logic     way1TagWrite;
  logic     way2TagWrite;
  logic [`SET_BITS+`OFFSET_BITS-1:0] dataIndex;

  // Address split
  assign addrTag = fetchAddr[`ADDR_BITS-1 -: `TAG_BITS];
  assign addrSet = fetchAddr[`OFFSET_BITS+2 +: `SET_BITS];

  // Word offset comes from the controller, beat counter during refills
  assign dataIndex = {addrSet, wordOffsetSel};

  assign newEntry = '{valid: 1'b1, tag: addrTag};

  // Tag only changes on the last beat of an enabled refill
  assign way1TagWrite = way1WriteEnable & tagWrite;
  assign way2TagWrite = way2WriteEnable & tagWrite;

  cacheArray #(.entryT(tagEntryT), .DEPTH(NUM_SETS)) way1Tags (
    .clk        (clk),
    .reset      (reset),
    .writeEnable(way1TagWrite),
    .writeIndex (addrSet),
    .readIndex  (addrSet),
    .writeData  (newEntry),
    .readData   (way1Entry)
  );

  cacheArray #(.entryT(tagEntryT), .DEPTH(NUM_SETS)) way2Tags (
    .clk        (clk),
    .reset      (reset),
    .writeEnable(way2TagWrite),
    .writeIndex (addrSet),
    .readIndex  (addrSet),
    .writeData  (newEntry),
    .readData   (way2Entry)
  );

  cacheArray #(.entryT(wordT), .DEPTH(NUM_WORDS)) way1Data (
    .clk        (clk),
    .reset      (reset),
    .writeEnable(way1WriteEnable),
    .writeIndex (dataIndex),
    .readIndex  (dataIndex),
    .writeData  (busData),
    .readData   (way1Word)
  );

  cacheArray #(.entryT(wordT), .DEPTH(NUM_WORDS)) way2Data (
    .clk        (clk),
    .reset      (reset),
    .writeEnable(way2WriteEnable),
    .writeIndex (dataIndex),
    .readIndex  (dataIndex),
    .writeData  (busData),
    .readData   (way2Word)
  );

  lruTable lru (
    .clk        (clk),
    .reset      (reset),
    .touch      (lruTouch),
    .touchSet   (addrSet),
    .readSet    (addrSet),
    .touchedWay1(waySel),
    .currLru    (currLru)
  );

  assign way1Valid = way1Entry.valid;
  assign way2Valid = way2Entry.valid;

  // With caching off nothing ever hits
  assign way1Hit = enable & way1Entry.valid & (way1Entry.tag == addrTag);
  assign way2Hit = enable & way2Entry.valid & (way2Entry.tag == addrTag);

  assign instr = waySel ? way1Word : way2Word;

  // Controller must pick a single way per beat
  oneWayWrite: assert property (@(posedge clk) disable iff (reset)
    !(way1WriteEnable && way2WriteEnable));

endmodule

//--- verilog/icacheController.sv
// Refill FSM of the instruction cache with beat counter and way choice
// Drives stall, bus request and address, and the array write controls

`include "icache_params.svh"

module icacheController
  import cacheLinePkg::*;
  import fetchBusPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    enable,
  input  logic    paReady,
  input  logic    busReady,
  input  addrT    fetchAddr,
  input  logic    way1Hit,
  input  logic    way2Hit,
  input  logic    way1Valid,
  input  logic    way2Valid,
  input  logic    currLru,
  output logic    iStall,
  output logic    busRequest,
  output addrT    busAddr,
  output wordOffT wordOffsetSel,
  output logic    way1WriteEnable,
  output logic    way2WriteEnable,
  output logic    tagWrite,
  output logic    waySel,
  output logic    lruTouch
);

  typedef enum logic [1:0] {READY, MEMREAD, NEXTINSTR} stateT;

  stateT   state;
  stateT   nextState;
  tagT     addrTag;
  setT     addrSet;
  wordOffT addrOff;
  wordOffT beatCount;
  wordOffT lineOffset;
  logic    hit;
  logic    missActive;
  logic    beat;
  logic    lastBeat;
  logic    clearCount;
  logic    fillWay1;
  logic    useWay1;

  assign addrTag = fetchAddr[`ADDR_BITS-1 -: `TAG_BITS];
  assign addrSet = fetchAddr[`OFFSET_BITS+2 +: `SET_BITS];
  assign addrOff = fetchAddr[2 +: `OFFSET_BITS];

  assign hit = (way1Hit | way2Hit) & paReady;

  // Miss in progress while the fetch address is valid
  assign missActive = paReady & ((state == MEMREAD) | ((state == READY) & ~hit));

  assign beat = missActive & busReady;
  // A disabled fetch needs just the one word
  assign lastBeat = beat & ((&beatCount) | ~enable);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        if (paReady & ~hit) begin
          nextState = lastBeat ? NEXTINSTR : MEMREAD;
        end
      end
      MEMREAD: begin
        if (lastBeat) begin
          nextState = NEXTINSTR;
        end
      end
      NEXTINSTR: nextState = READY;
      default:   nextState = READY;
    endcase
  end

  assign iStall = missActive;
  assign busRequest = missActive;

  // Counter restarts once the fetch is served
  assign clearCount = ((state == READY) & hit) | (state == NEXTINSTR);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beatCount <= '0;
    end else if (clearCount) begin
      beatCount <= '0;
    end else if (beat) begin
      beatCount <= beatCount + 1'b1;
    end
  end

  // Enabled refills walk the line from word 0
  assign lineOffset = enable ? beatCount : addrOff;
  assign wordOffsetSel = clearCount ? addrOff : lineOffset;

  assign busAddr = {addrTag, addrSet, lineOffset, 2'b00};

  // An invalid way is filled before the LRU way
  assign fillWay1 = (~way1Valid & way2Valid) | currLru;
  assign useWay1 = ~enable | fillWay1;

  assign way1WriteEnable = beat & useWay1;
  assign way2WriteEnable = beat & ~useWay1;
  assign tagWrite = beat & enable & (&beatCount);

  // Freshly filled way hits again in NEXTINSTR
  assign waySel = ~enable | way1Hit;

  assign lruTouch = enable & (((state == READY) & hit) | (state == NEXTINSTR));

  // The line being refilled never hits before its tag is written
  noRequestOnHit: assert property (@(posedge clk) disable iff (reset)
    busRequest |-> !(way1Hit || way2Hit));

  // Final beat comes after the first one, and the written tag then hits
  tagWriteHits: assert property (@(posedge clk) disable iff (reset)
    tagWrite |-> (state == MEMREAD) ##1 ((state == NEXTINSTR) && (way1Hit || way2Hit)));

endmodule

//--- verilog/icacheTop.sv
// Instruction cache top level
// Connects the refill controller to the tag and data datapath

module icacheTop
  import cacheLinePkg::*;
  import fetchBusPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic enable,
  input  logic paReady,
  input  logic busReady,
  input  addrT fetchAddr,
  input  wordT busData,
  output wordT instr,
  output logic iStall,
  output logic busRequest,
  output addrT busAddr
);

  logic    way1Hit;
  logic    way2Hit;
  logic    way1Valid;
  logic    way2Valid;
  logic    currLru;
  logic    way1WriteEnable;
  logic    way2WriteEnable;
  logic    tagWrite;
  logic    waySel;
  logic    lruTouch;
  wordOffT wordOffsetSel;

  icacheController ctrl (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .paReady        (paReady),
    .busReady       (busReady),
    .fetchAddr      (fetchAddr),
    .way1Hit        (way1Hit),
    .way2Hit        (way2Hit),
    .way1Valid      (way1Valid),
    .way2Valid      (way2Valid),
    .currLru        (currLru),
    .iStall         (iStall),
    .busRequest     (busRequest),
    .busAddr        (busAddr),
    .wordOffsetSel  (wordOffsetSel),
    .way1WriteEnable(way1WriteEnable),
    .way2WriteEnable(way2WriteEnable),
    .tagWrite       (tagWrite),
    .waySel         (waySel),
    .lruTouch       (lruTouch)
  );

  icacheDatapath dp (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .fetchAddr      (fetchAddr),
    .wordOffsetSel  (wordOffsetSel),
    .way1WriteEnable(way1WriteEnable),
    .way2WriteEnable(way2WriteEnable),
    .tagWrite       (tagWrite),
    .waySel         (waySel),
    .lruTouch       (lruTouch),
    .busData        (busData),
    .instr          (instr),
    .way1Hit        (way1Hit),
    .way2Hit        (way2Hit),
    .way1Valid      (way1Valid),
    .way2Valid      (way2Valid),
    .currLru        (currLru)
  );

endmodule

//--- bench/fetchMemModel.sv
// Bus memory model for the instruction cache testbench
// Random wait states per beat, word at address A is ~A

module fetchMemModel
  import fetchBusPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       busRequest,
  input  addrT       busAddr,
  output logic       busReady,
  output wordT       busData,
  output logic [7:0] burstBeats
);

  timeunit 1ns;
  timeprecision 100ps;

  int seed = 11;
  logic [1:0] waitLeft;

  initial begin
    busReady = 1'b0;
  end

  // Memory answers with the word at the current bus address
  assign busData = ~busAddr;

  // Wait count for the next beat is drawn when a beat completes
  always @(posedge clk or posedge reset) begin
    int pick;
    if (reset) begin
      waitLeft <= 2'd0;
    end else if (busRequest && busReady) begin
      pick = $random(seed);
      waitLeft <= pick[1:0];
    end else if (busRequest && waitLeft != 2'd0) begin
      waitLeft <= waitLeft - 2'd1;
    end
  end

  always @(negedge clk) begin
    busReady <= (waitLeft == 2'd0);
  end

  // Beats seen since busRequest last went low
  always @(posedge clk or posedge reset) begin
    if (reset || !busRequest) begin
      burstBeats <= 8'd0;
    end else if (busReady) begin
      burstBeats <= burstBeats + 8'd1;
    end
  end

endmodule

//--- bench/icacheTb.sv
// Instruction cache testbench with clock, reset, fetch sequences and watchdog
// Concurrent assertions check data, hit or miss, refill beats and bus waits

`include "icache_params.svh"

module icacheTb
  import cacheLinePkg::*;
  import fetchBusPkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int LINE_LSB = `OFFSET_BITS + 2;
  localparam int NUM_SETS = 1 << `SET_BITS;
  localparam int SWEEP_FETCHES = 24;
  localparam int NUM_FETCHES = 17 + SWEEP_FETCHES;
  // A miss takes at most 4 beats of 4 cycles, plus reset and idle time
  localparam int WATCHDOG_CYCLES = NUM_FETCHES * 20 + 40;

  typedef logic [`ADDR_BITS-LINE_LSB-1:0] lineT;

  logic       clk = 1'b0;
  logic       reset;
  logic       enable;
  logic       paReady;
  addrT       fetchAddr;
  wordT       instr;
  logic       iStall;
  logic       busRequest;
  addrT       busAddr;
  logic       busReady;
  wordT       busData;
  logic [7:0] burstBeats;

  logic fetchStart;
  logic expectHit;
  logic lastStall = 1'b0;
  logic prevWait = 1'b0;
  addrT heldBusAddr;
  int   dataErrors = 0;
  int   flowErrors = 0;
  int   busErrors = 0;

  // Residency per set, most and least recently used line
  lineT mruLine [NUM_SETS];
  lineT lruLine [NUM_SETS];
  logic mruValid [NUM_SETS];
  logic lruValid [NUM_SETS];

  icacheTop dut (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .paReady   (paReady),
    .busReady  (busReady),
    .fetchAddr (fetchAddr),
    .busData   (busData),
    .instr     (instr),
    .iStall    (iStall),
    .busRequest(busRequest),
    .busAddr   (busAddr)
  );

  fetchMemModel mem (
    .clk       (clk),
    .reset     (reset),
    .busRequest(busRequest),
    .busAddr   (busAddr),
    .busReady  (busReady),
    .busData   (busData),
    .burstBeats(burstBeats)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    lastStall <= iStall;
    prevWait <= busRequest && !busReady && !reset;
    heldBusAddr <= busAddr;
  end

  // Enabled refills walk the line from word 0, disabled ones take one word
  function automatic addrT expectedBeatAddr(input addrT a, input logic en,
                                            input logic [7:0] beats);
    addrT word;
    word = a;
    if (en) begin
      word[2 +: `OFFSET_BITS] = beats[`OFFSET_BITS-1:0];
    end
    word[1:0] = 2'b00;
    return word;
  endfunction

  // Updates residency for an enabled fetch and reports a hit
  task automatic touchLine(input addrT a, output logic hit);
    lineT line;
    setT  s;
    line = a[`ADDR_BITS-1:LINE_LSB];
    s = a[LINE_LSB +: `SET_BITS];
    hit = 1'b0;
    if (mruValid[s] && mruLine[s] == line) begin
      hit = 1'b1;
    end else if (lruValid[s] && lruLine[s] == line) begin
      hit = 1'b1;
      lruLine[s] = mruLine[s];
      mruLine[s] = line;
    end else begin
      lruLine[s] = mruLine[s];
      lruValid[s] = mruValid[s];
      mruLine[s] = line;
      mruValid[s] = 1'b1;
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the fetch is served
  task automatic fetchWord(input addrT a);
    logic hit;
    hit = 1'b0;
    if (enable) begin
      touchLine(a, hit);
    end
    fetchAddr = a;
    paReady = 1'b1;
    fetchStart = 1'b1;
    expectHit = hit;
    @(negedge clk);
    fetchStart = 1'b0;
    while (lastStall) begin
      @(negedge clk);
    end
  endtask

  task automatic idleCycles(input int n);
    paReady = 1'b0;
    fetchStart = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic runSweep();
    int   tagSel;
    int   setSel;
    int   offSel;
    addrT a;
    for (int i = 0; i < SWEEP_FETCHES; i++) begin
      tagSel = (i * 7 % 5) % 3 + 1;
      setSel = (i / 2) % 2;
      offSel = (i * 3) % 4;
      a = (tagSel << 16) | (setSel << 4) | (offSel << 2);
      fetchWord(a);
    end
  endtask

  initial begin
    reset = 1'b1;
    enable = 1'b0;
    paReady = 1'b0;
    fetchAddr = '0;
    fetchStart = 1'b0;
    expectHit = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      mruValid[s] = 1'b0;
      lruValid[s] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idleCycles(3);

    // One line refilled, then every word of it hits
    enable = 1'b1;
    fetchWord(32'h0000_1030);
    fetchWord(32'h0000_1034);
    fetchWord(32'h0000_1038);
    fetchWord(32'h0000_103C);
    fetchWord(32'h0000_1030);
    idleCycles(1);

    // A, B, A, C, A, B in set 5
    fetchWord(32'h0000_2050);
    fetchWord(32'h0000_3054);
    fetchWord(32'h0000_2058);
    fetchWord(32'h0000_405C);
    fetchWord(32'h0000_2050);
    fetchWord(32'h0000_3058);

    runSweep();

    // Sets 14 and 15 are left to uncached fetches
    enable = 1'b0;
    fetchWord(32'h0005_00E4);
    fetchWord(32'h0005_00E8);
    fetchWord(32'h0006_00F0);
    enable = 1'b1;
    fetchWord(32'h0005_00E4);
    fetchWord(32'h0005_00EC);
    fetchWord(32'h0006_00F8);
    idleCycles(2);

    $display("Errors: data %0d, hit or miss %0d, bus %0d", dataErrors, flowErrors, busErrors);
    if (dataErrors + flowErrors + busErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before all fetches were served");
    $display("Errors: data %0d, hit or miss %0d, bus %0d", dataErrors, flowErrors, busErrors);
    $display("Some tests failed");
    $finish;
  end

  idleWhenNoFetch: assert property (@(posedge clk) disable iff (reset)
    !paReady |-> (!busRequest && !iStall))
    else begin
      flowErrors++;
      $display("FAIL iStall: got %h busRequest: got %h expected 0 with paReady low",
               $sampled(iStall), $sampled(busRequest));
    end

  instrValue: assert property (@(posedge clk) disable iff (reset)
    (paReady && !iStall) |-> (instr == ~fetchAddr))
    else begin
      dataErrors++;
      $display("FAIL instr: got %h expected %h", $sampled(instr), ~$sampled(fetchAddr));
    end

  hitOrMiss: assert property (@(posedge clk) disable iff (reset)
    fetchStart |-> ((iStall != expectHit) && (busRequest != expectHit)))
    else begin
      flowErrors++;
      $display("FAIL iStall: got %h busRequest: got %h expected %h at %h",
               $sampled(iStall), $sampled(busRequest), !$sampled(expectHit),
               $sampled(fetchAddr));
    end

  beatAddress: assert property (@(posedge clk) disable iff (reset)
    (busRequest && busReady) |-> (busAddr == expectedBeatAddr(fetchAddr, enable, burstBeats)))
    else begin
      busErrors++;
      $display("FAIL busAddr: got %h expected %h", $sampled(busAddr),
               expectedBeatAddr($sampled(fetchAddr), $sampled(enable), $sampled(burstBeats)));
    end

  waitHoldsAddr: assert property (@(posedge clk) disable iff (reset)
    prevWait |-> (busAddr == heldBusAddr))
    else begin
      busErrors++;
      $display("FAIL busAddr: got %h expected %h after a wait cycle",
               $sampled(busAddr), $sampled(heldBusAddr));
    end

  // Four beats per enabled refill, one per uncached fetch
  burstLength: assert property (@(posedge clk) disable iff (reset)
    $fell(iStall) |-> (burstBeats == (enable ? 8'd4 : 8'd1)))
    else begin
      busErrors++;
      $display("FAIL burstBeats: got %h expected %h", $sampled(burstBeats),
               $sampled(enable) ? 8'd4 : 8'd1);
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/cacheLinePkg.sv
verilog/fetchBusPkg.sv
verilog/cacheArray.sv
verilog/lruTable.sv
verilog/icacheDatapath.sv
verilog/icacheController.sv
verilog/icacheTop.sv
bench/fetchMemModel.sv
bench/icacheTb.sv

//--- Makefile
# Verilator lint and simulation of the instruction cache testbench

TOP = icacheTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
